//--- flist.f
i2c_pkg.sv
i2c_tick_gen.sv
i2c_line_io.sv
i2c_master.sv
i2c_subsys_top.sv
tb_i2c_target.sv
tb_i2c.sv

//--- run.sh
#!/bin/bash
# Build with Verilator and run the I2C testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_i2c -o sim_i2c \
    && ./obj_dir/sim_i2c | grep -F "Done: no errors" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

//--- tb_i2c.sv
module tb_i2c;

    timeunit 1ns;
    timeprecision 100ps;

    import i2c_pkg::*;

    typedef struct packed {
        logic [6:0] addr;
        i2c_dir_e   dir;
        logic [2:0] nbytes;
        logic [3:0] hold;
        logic [2:0] nack_at;
        logic       exp_nack;
        logic [2:0] exp_bytes;                // Bytes the target should log
    } row_t;

    localparam int n_rows = 12;
    localparam row_t rows [n_rows] = '{
        '{7'h2A, dir_write, 3'd1, 4'd0, 3'd0, 1'b0, 3'd1},
        '{7'h2A, dir_write, 3'd2, 4'd0, 3'd0, 1'b0, 3'd2},
        '{7'h2A, dir_write, 3'd3, 4'd0, 3'd0, 1'b0, 3'd3},
        '{7'h2A, dir_write, 3'd4, 4'd0, 3'd0, 1'b0, 3'd4},
        '{7'h2A, dir_read,  3'd1, 4'd0, 3'd0, 1'b0, 3'd1},
        '{7'h2A, dir_read,  3'd2, 4'd0, 3'd0, 1'b0, 3'd2},
        '{7'h2A, dir_read,  3'd3, 4'd0, 3'd0, 1'b0, 3'd3},
        '{7'h2A, dir_read,  3'd4, 4'd0, 3'd0, 1'b0, 3'd4},
        '{7'h33, dir_write, 3'd2, 4'd0, 3'd0, 1'b1, 3'd0},
        '{7'h33, dir_read,  3'd2, 4'd0, 3'd0, 1'b1, 3'd0},
        '{7'h2A, dir_write, 3'd4, 4'd0, 3'd2, 1'b1, 3'd2},
        '{7'h2A, dir_write, 3'd3, 4'd5, 3'd0, 1'b0, 3'd3}
    };
    localparam logic [7:0] mem_ref [4] = '{8'hA5, 8'h3C, 8'h96, 8'h0F};

    logic      clk;
    logic      rst_n;
    logic      start;
    i2c_req_t  req;
    logic      busy;
    logic      done;
    i2c_rsp_t  rsp;
    i2c_pins_t drive;
    i2c_pins_t lines;
    logic      tgt_pull;
    logic      tgt_holding;
    logic      arm;
    int        hold_cnt;
    int        nack_at;
    int        done_cnt = 0;
    int        err_rsp;
    int        err_byte;
    int        err_other;
    logic [15:0] lfsr_q;

    i2c_subsys_top #(.DIVIDER(3)) dut (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .req   (req),
        .busy  (busy),
        .done  (done),
        .rsp   (rsp),
        .drive (drive),
        .lines (lines)
    );

    tb_i2c_target tgt (
        .scl      (lines.scl),
        .sda      (lines.sda),
        .arm      (arm),
        .hold_cnt (hold_cnt),
        .nack_at  (nack_at),
        .sda_pull (tgt_pull),
        .holding  (tgt_holding)
    );

    assign lines = {~drive.scl, ~(drive.sda | tgt_pull)};  // Wired-AND bus

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (done) begin
            done_cnt <= done_cnt + 1;
        end
    end

    // ############################################################
    // Stimulus helpers and checks
    // ############################################################
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        b = '0;
        for (int k = 0; k < 8; k++) begin
            lfsr_q = lfsr_next(lfsr_q);     // One step per bit
            b = {b[6:0], lfsr_q[0]};
        end
        return b;
    endfunction

    task automatic check_rsp(input i2c_rsp_t got, input i2c_rsp_t exp);
        if (got !== exp) begin
            $display("ERROR %0t: rsp rdata=%h nack=%b, expected rdata=%h nack=%b",
                     $time, got.rdata, got.nack, exp.rdata, exp.nack);
            err_rsp++;
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
            err_byte++;
        end
    endtask

    task automatic wait_busy();
        int n;
        n = 0;
        while (!busy && n < 2000) begin
            start = 1'b1;                     // Held until the DUT takes it
            @(posedge clk);
            #1;
            start = 1'b0;
            n++;
        end
        if (!busy) begin
            $display("Request was never accepted at %0t", $time);
            err_other++;
        end
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!done && n < 2000) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!done) begin
            $display("No done within 2000 cycles, master in %s", dut.u_master.state_q.name());
            err_other++;
        end
    endtask

    // ############################################################
    // Main sequence
    // ############################################################
    initial begin
        row_t     r;
        i2c_rsp_t exp;
        int       nb;
        rst_n = 1'b0;
        start = 1'b0;
        req = '0;
        arm = 1'b0;
        hold_cnt = 0;
        nack_at = 0;
        err_rsp = 0;
        err_byte = 0;
        err_other = 0;
        lfsr_q = 16'd50044;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_byte({7'b0, busy}, 8'h00, "busy after reset");
        check_byte({7'b0, done}, 8'h00, "done after reset");
        check_byte({6'b0, drive}, 8'h00, "drive after reset");
        check_rsp(rsp, '0);

        for (int i = 0; i < n_rows; i++) begin
            r = rows[i];
            nb = int'(r.nbytes);
            req = '0;
            req.addr = r.addr;
            req.dir = r.dir;
            req.nbytes = r.nbytes;
            for (int b = 0; b < nb; b++) begin
                req.wdata[8*b +: 8] = rand_byte();
            end
            exp = '0;
            exp.nack = r.exp_nack;
            if (r.dir == dir_read && !r.exp_nack) begin
                for (int b = 0; b < nb; b++) begin
                    exp.rdata = {exp.rdata[23:0], mem_ref[b]};
                end
            end

            hold_cnt = int'(r.hold);
            nack_at = int'(r.nack_at);
            arm = 1'b1;
            @(posedge clk);
            #1;
            arm = 1'b0;
            if (r.hold != 0) begin
                repeat (10) @(posedge clk);   // Let the master see SDA low
            end
            #1;
            wait_busy();
            check_byte({7'b0, tgt_holding}, 8'h00, "SDA hold at acceptance");

            start = 1'b1;                     // Strobe while busy that must be ignored
            req.addr = 7'h33;
            @(posedge clk);
            #1;
            start = 1'b0;

            wait_done();
            check_byte({7'b0, busy}, 8'h00, "busy at done");
            check_rsp(rsp, exp);
            if (r.dir == dir_write) begin
                check_byte(8'(tgt.wr_q.size()), 8'(r.exp_bytes), "written byte count");
                for (int k = 0; k < int'(r.exp_bytes) && k < tgt.wr_q.size(); k++) begin
                    check_byte(tgt.wr_q[k], req.wdata[8*(nb-1-k) +: 8], "written byte");
                end
            end else begin
                check_byte(8'(tgt.ack_q.size()), 8'(r.exp_bytes), "master ack count");
                for (int k = 0; k < tgt.ack_q.size(); k++) begin
                    check_byte({7'b0, tgt.ack_q[k]}, {7'b0, k == nb - 1}, "master ack bit");
                end
            end
            if (r.hold != 0) begin
                check_byte(8'(tgt.held_edges), 8'(r.hold), "SCL edges while held");
            end
            repeat (3) @(posedge clk);
            #1;
            check_byte(8'(done_cnt), 8'(i + 1), "done count");
        end

        $display("Errors: rsp=%0d byte=%0d other=%0d", err_rsp, err_byte, err_other);
        if (err_rsp + err_byte + err_other == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- tb_i2c_target.sv
module tb_i2c_target (
    input  logic scl,
    input  logic sda,
    input  logic arm,                         // Rising edge clears logs and loads the hold
    input  int   hold_cnt,
    input  int   nack_at,                     // Written byte count that gets a NACK, 0 for none
    output logic sda_pull,
    output logic holding
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0] mem [4] = '{8'hA5, 8'h3C, 8'h96, 8'h0F};
    logic [7:0] wr_q [$];                     // Written bytes in bus order
    logic       ack_q [$];                    // Master ack bits after read bytes
    int         held_edges = 0;
    int         hold_left  = 0;
    int         bitn       = 0;
    int         nbyte      = 0;
    logic       pull       = 1'b0;
    logic       active     = 1'b0;
    logic       quiet      = 1'b0;
    logic       rd         = 1'b0;
    logic       got        = 1'b0;
    logic [7:0] sh         = '0;
    logic [7:0] rbyte      = '0;
    logic       prev_scl   = 1'b1;
    logic       prev_sda   = 1'b1;
    logic       prev_arm   = 1'b0;

    assign holding  = (hold_left > 0);
    assign sda_pull = pull | holding;

    // ############################################################
    // Bus watcher
    // ############################################################
    always @(scl or sda or arm) begin
        if (arm && !prev_arm) begin
            wr_q.delete();
            ack_q.delete();
            held_edges = 0;
            hold_left  = hold_cnt;
            active     = 1'b0;
            pull       = 1'b0;
        end else if (hold_left > 0) begin
            if (scl != prev_scl) begin       // Recovery clock edge
                hold_left  = hold_left - 1;
                held_edges = held_edges + 1;
            end
        end else if (scl && prev_scl && sda != prev_sda) begin
            active = !sda;                   // Start or stop
            bitn   = 0;
            nbyte  = 0;
            quiet  = 1'b0;
            got    = 1'b0;
            pull   = 1'b0;
        end else if (active && scl && !prev_scl) begin
            got = 1'b1;
            if (bitn < 8) begin
                sh = {sh[6:0], sda};
            end else if (rd && nbyte > 0) begin
                ack_q.push_back(sda);
                if (sda) quiet = 1'b1;       // Master ended the read
            end
        end else if (active && !scl && prev_scl && got) begin
            got = 1'b0;
            if (bitn < 7) begin
                bitn = bitn + 1;
                if (rd && nbyte > 0 && !quiet) pull = ~rbyte[3'(7 - bitn)];
            end else if (bitn == 7) begin
                bitn = 8;
                if (nbyte == 0) begin
                    rd = sh[0];
                    pull  = (sh[7:1] == 7'h2A);
                    quiet = (sh[7:1] != 7'h2A);
                end else if (!rd) begin
                    wr_q.push_back(sh);
                    quiet = (wr_q.size() == nack_at);
                    pull  = !quiet;
                end else begin
                    pull = 1'b0;             // Master owns the ack slot
                end
            end else begin
                bitn  = 0;
                nbyte = nbyte + 1;
                pull  = 1'b0;
                if (rd && !quiet) begin
                    rbyte = mem[(nbyte - 1) % 4];
                    pull  = ~rbyte[7];
                end
            end
        end
        prev_scl = scl;
        prev_sda = sda;
        prev_arm = arm;
    end

endmodule

//--- i2c_subsys_top.sv
module i2c_subsys_top #(
    parameter int DIVIDER = 42
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  i2c_pkg::i2c_req_t  req,
    output logic               busy,
    output logic               done,
    output i2c_pkg::i2c_rsp_t  rsp,
    output i2c_pkg::i2c_pins_t drive,
    input  i2c_pkg::i2c_pins_t lines
);

    import i2c_pkg::*;

    logic      tick;
    logic      bus_free;
    i2c_pins_t line_sync;
    i2c_pins_t drive_req;

    i2c_tick_gen #(
        .DIVIDER (DIVIDER)
    ) u_tick_gen (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick)
    );

    i2c_line_io u_line_io (
        .clk       (clk),
        .rst_n     (rst_n),
        .drive_req (drive_req),
        .drive     (drive),
        .lines     (lines),
        .line_sync (line_sync),
        .bus_free  (bus_free)
    );

    i2c_master u_master (
        .clk       (clk),
        .rst_n     (rst_n),
        .tick      (tick),
        .start     (start),
        .req       (req),
        .busy      (busy),
        .done      (done),
        .rsp       (rsp),
        .line_sync (line_sync),
        .bus_free  (bus_free),
        .drive_req (drive_req)
    );

endmodule

//--- i2c_master.sv
module i2c_master (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               tick,
    input  logic               start,
    input  i2c_pkg::i2c_req_t  req,
    output logic               busy,
    output logic               done,
    output i2c_pkg::i2c_rsp_t  rsp,
    input  i2c_pkg::i2c_pins_t line_sync,
    input  logic               bus_free,
    output i2c_pkg::i2c_pins_t drive_req
);

    import i2c_pkg::*;

    i2c_state_e state_q;
    i2c_req_t   req_q;
    i2c_rsp_t   rsp_q;
    i2c_pins_t  drive_q;                      // 1 pulls the line low
    logic [1:0] phase_q;
    logic [2:0] bit_cnt_q;
    logic [2:0] byte_cnt_q;                   // 0 is the address byte
    logic [7:0] shift_q;
    logic       busy_q;
    logic       done_q;
    logic       accept;
    logic       sending;
    logic       last_byte;

    assign accept    = start && !busy_q && (state_q == st_idle) && bus_free;
    assign sending   = (byte_cnt_q == '0) || (req_q.dir == dir_write);
    assign last_byte = (byte_cnt_q == req_q.nbytes);

    // ############################################################
    // Transfer sequencer
    // ############################################################
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= st_idle;
            phase_q    <= '0;
            bit_cnt_q  <= '0;
            byte_cnt_q <= '0;
            drive_q    <= '0;
            busy_q     <= 1'b0;
            done_q     <= 1'b0;
            rsp_q      <= '0;
        end else begin
            done_q <= 1'b0;
            if (accept) begin
                req_q       <= req;
                // Left-align so the next byte to send is always the top one
                req_q.wdata <= req.wdata << (8 * (max_bytes - int'(req.nbytes)));
                rsp_q       <= '0;
                busy_q      <= 1'b1;
                phase_q     <= '0;
                state_q     <= st_start;
            end else if (tick) begin
                case (state_q)
                    st_idle: begin
                        if (!bus_free && !line_sync.sda) begin
                            drive_q.scl <= 1'b1;      // First recovery clock edge
                            state_q     <= st_recover;
                        end
                    end

                    st_recover: begin
                        if (line_sync.sda) begin
                            drive_q.scl <= 1'b0;
                            state_q     <= st_idle;
                        end else begin
                            drive_q.scl <= ~drive_q.scl;
                        end
                    end

                    st_start: begin
                        case (phase_q)
                            2'd0: begin
                                drive_q <= '0;
                                phase_q <= 2'd1;
                            end
                            2'd1: begin
                                drive_q.sda <= 1'b1;  // SDA falls while SCL high
                                phase_q     <= 2'd2;
                            end
                            default: begin
                                drive_q.scl <= 1'b1;
                                shift_q     <= {req_q.addr, req_q.dir};
                                bit_cnt_q   <= '0;
                                byte_cnt_q  <= '0;
                                phase_q     <= '0;
                                state_q     <= st_shift;
                            end
                        endcase
                    end

                    st_shift: begin
                        case (phase_q)
                            2'd0: begin
                                drive_q.sda <= sending ? ~shift_q[7] : 1'b0;
                                phase_q     <= 2'd1;
                            end
                            2'd1: begin
                                drive_q.scl <= 1'b0;
                                if (!sending) begin
                                    shift_q <= {shift_q[6:0], line_sync.sda};
                                end
                                phase_q <= 2'd2;
                            end
                            default: begin
                                drive_q.scl <= 1'b1;
                                if (sending) begin
                                    shift_q <= {shift_q[6:0], 1'b0};
                                end
                                bit_cnt_q <= bit_cnt_q + 3'd1;
                                if (bit_cnt_q == 3'd7) begin
                                    state_q <= st_ack;
                                end
                                phase_q <= '0;
                            end
                        endcase
                    end

                    st_ack: begin
                        case (phase_q)
                            2'd0: begin
                                if (sending) begin
                                    drive_q.sda <= 1'b0;      // Let the target answer
                                end else begin
                                    drive_q.sda <= ~last_byte; // NACK the final read
                                    rsp_q.rdata <= {rsp_q.rdata[data_w-9:0], shift_q};
                                end
                                phase_q <= 2'd1;
                            end
                            2'd1: begin
                                drive_q.scl <= 1'b0;
                                if (sending && line_sync.sda) begin
                                    rsp_q.nack <= 1'b1;
                                end
                                phase_q <= 2'd2;
                            end
                            default: begin
                                drive_q.scl <= 1'b1;
                                if (rsp_q.nack || last_byte) begin
                                    state_q <= st_stop;
                                end else begin
                                    byte_cnt_q  <= byte_cnt_q + 3'd1;
                                    shift_q     <= req_q.wdata[data_w-1 -: 8];
                                    req_q.wdata <= req_q.wdata << 8;
                                    state_q     <= st_shift;
                                end
                                phase_q <= '0;
                            end
                        endcase
                    end

                    st_stop: begin
                        case (phase_q)
                            2'd0: begin
                                drive_q.sda <= 1'b1;
                                phase_q     <= 2'd1;
                            end
                            2'd1: begin
                                drive_q.scl <= 1'b0;
                                phase_q     <= 2'd2;
                            end
                            2'd2: begin
                                drive_q.sda <= 1'b0;  // SDA rises while SCL high
                                phase_q     <= 2'd3;
                            end
                            default: begin
                                busy_q  <= 1'b0;
                                done_q  <= 1'b1;
                                phase_q <= '0;
                                state_q <= st_idle;
                            end
                        endcase
                    end

                    default: begin
                        drive_q <= '0;
                        state_q <= st_idle;
                    end
                endcase
            end
        end
    end

    assign busy      = busy_q;
    assign done      = done_q;
    assign rsp       = rsp_q;
    assign drive_req = drive_q;

endmodule

//--- i2c_line_io.sv
module i2c_line_io (
    input  logic               clk,
    input  logic               rst_n,
    input  i2c_pkg::i2c_pins_t drive_req,
    output i2c_pkg::i2c_pins_t drive,
    input  i2c_pkg::i2c_pins_t lines,
    output i2c_pkg::i2c_pins_t line_sync,
    output logic               bus_free
);

    import i2c_pkg::*;

    i2c_pins_t drive_q;
    i2c_pins_t sync_q1;
    i2c_pins_t sync_q2;

    // ############################################################
    // Pad side registers
    // ############################################################
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            drive_q <= '0;                    // Both lines released
            sync_q1 <= '1;                    // Idle bus reads high
            sync_q2 <= '1;
        end else begin
            drive_q <= drive_req;
            sync_q1 <= lines;                 // First stage may go metastable
            sync_q2 <= sync_q1;
        end
    end

    assign drive     = drive_q;
    assign line_sync = sync_q2;

    // Both lines high means nobody holds the bus
    assign bus_free = sync_q2.scl & sync_q2.sda;

endmodule

//--- i2c_tick_gen.sv
module i2c_tick_gen #(
    parameter int DIVIDER = 42
) (
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    localparam int cnt_w = (DIVIDER > 1) ? $clog2(DIVIDER + 1) : 1;

    logic [cnt_w-1:0] cnt_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt_q <= cnt_w'(DIVIDER);         // Parked at reload during reset
        end else if (cnt_q == '0) begin
            cnt_q <= cnt_w'(DIVIDER);
        end else begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // One pulse per DIVIDER+1 clocks sets the bus phase rate
    assign tick = (cnt_q == '0);

endmodule

//--- i2c_pkg.sv
package i2c_pkg;

    // ############################################################
    // Fixed sizes
    // ############################################################
    localparam int max_bytes = 4;            // Longest transfer in bytes
    localparam int data_w    = max_bytes * 8; // Width of the data words

    // ############################################################
    // Enums
    // ############################################################
    typedef enum logic {
        dir_write = 1'b0,
        dir_read  = 1'b1
    } i2c_dir_e;                             // R/W bit after the address

    typedef enum logic [2:0] {
        st_idle    = 3'd0,
        st_recover = 3'd1,
        st_start   = 3'd2,
        st_shift   = 3'd3,
        st_ack     = 3'd4,
        st_stop    = 3'd5
    } i2c_state_e;

    // ############################################################
    // Structs
    // ############################################################
    typedef struct packed {
        logic [6:0]        addr;
        i2c_dir_e          dir;
        logic [2:0]        nbytes;           // 1 to max_bytes
        logic [data_w-1:0] wdata;            // Byte nbytes-1 goes out first
    } i2c_req_t;

    typedef struct packed {
        logic [data_w-1:0] rdata;            // Last byte read sits in 7:0
        logic              nack;
    } i2c_rsp_t;

    typedef struct packed {
        logic scl;
        logic sda;
    } i2c_pins_t;

endpackage
